/* decodeFront.f */
+incdir+tb
hw/isaPkg.sv
hw/decodePkg.sv
hw/fpCvt32To64.sv
hw/decodeImm.sv
hw/insQueue.sv
hw/decodeStage.sv
hw/decodeFront.sv
tb/decodeFrontTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary -Wno-fatal
TOP      = decodeFrontTb
FILELIST = decodeFront.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)

/* tb/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ====================
// Stimulus source
// ====================

logic [15:0] lfsr = 16'd51;

// Every opcode that may start a group, one of each class at least
localparam opcode_t BASE_OPS [29] = '{
	OP_NOP, OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_ANDI, OP_ORI,
	OP_EORI, OP_CSR, OP_RTD, OP_JSR, OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
	OP_LDO, OP_LDA, OP_CACHE, OP_STB, OP_STW, OP_STT, OP_STO, OP_FENCE, OP_FLT2, OP_FLT3
};
localparam opcode_t PFX_KINDS [3] = '{OP_PFXA, OP_PFXB, OP_PFXC};

// Taps 16, 14, 13 and 11 give a maximal length sequence, one step per bit taken
function automatic logic [63:0] randBits(input int n);
	logic [63:0] r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		r = {r[62:0], fb};
	end
	return r;
endfunction

// ====================
// Immediate rules
// ====================

// Single to double by field rules, denormals normalized one shift at a time
function automatic logic [63:0] widenSingle(input logic [31:0] s);
	logic [10:0] e;
	logic [23:0] m;
	m = {1'b0, s[22:0]};
	if (s[30:23] == 8'hFF)
		e = 11'h7FF;
	else if (s[30:23] != 8'd0)
		e = 11'(s[30:23]) - 11'd127 + 11'd1023;
	else if (m == 24'd0)
		e = 11'd0;
	else begin
		// Smallest normal single exponent is -126, one more shift per leading zero
		e = 11'd897;
		for (int i = 0; i < 23; i++) begin
			if (!m[23]) begin
				m = m << 1;
				e = e - 11'd1;
			end
		end
	end
	return {s[31], e, m[22:0], 29'd0};
endfunction

// Classes are zero, normal, denormal, infinity and NaN
function automatic logic [31:0] floatPattern(input int cls);
	logic [31:0] r;
	r = 32'(randBits(32));
	case (cls)
		0: r[30:0] = '0;
		1: if (r[30:23] == 8'd0 || r[30:23] == 8'hFF) r[30:23] = 8'd127;
		2: begin
			r[30:23] = 8'd0;
			if (r[22:0] == 23'd0) r[0] = 1'b1;
		end
		3: begin
			r[30:23] = 8'hFF;
			r[22:0] = '0;
		end
		default: begin
			r[30:23] = 8'hFF;
			if (r[22:0] == 23'd0) r[22] = 1'b1;
		end
	endcase
	return r;
endfunction

function automatic logic [63:0] baseImm(input instruction_t p);
	logic [15:0] s;
	s = p[IMM_HI:IMM_LO];
	case (p.opcode)
		OP_ANDI: return {{48{1'b1}}, s};
		OP_ORI, OP_EORI: return 64'(s);
		OP_CSR: return 64'(s[13:0]);
		OP_RTD: return {32'd0, 32'($signed(s))};
		OP_FENCE: return 64'(p[FENCE_HI:FENCE_LO]);
		OP_NOP, OP_FLT2, OP_FLT3: return 64'd0;
		// Arithmetic, loads, stores and JSR
		default: return 64'($signed(s));
	endcase
endfunction

// ====================
// Group builder
// ====================

// A negative class picks the float pattern at random
task automatic buildGroup(input opcode_t op, input int na, input int nb, input int nc,
		input int fcls);
	int n [3];
	logic [63:0] imm [3];
	instruction_t p;
	decodedIns_t want;
	logic flt;
	n = '{na, nb, nc};
	flt = (op == OP_FLT2) || (op == OP_FLT3);
	p.opcode = op;
	p.payload = 33'(randBits(33));
	want.opcode = op;
	want.ins = p;
	want.prefixCount = prefixCount_t'(na + nb + nc);
	imm = '{64'd0, baseImm(p), 64'd0};
	sendQ.push_back(p);
	for (int k = 0; k < 3; k++) begin
		for (int j = 0; j < n[k]; j++) begin
			p.opcode = PFX_KINDS[k];
			p.payload = 33'(randBits(33));
			if (j == 1)
				// The repeat fills the top 31 bits and keeps the low 33
				imm[k][63:33] = p.payload[30:0];
			else if (flt) begin
				p.payload[31:0] = floatPattern(fcls >= 0 ? fcls : int'(randBits(3) % 64'd5));
				imm[k] = widenSingle(p.payload[31:0]);
			end
			else
				imm[k] = 64'($signed(p.payload));
			sendQ.push_back(p);
		end
	end
	want.imma = imm[0];
	want.immb = imm[1];
	want.immc = imm[2];
	expQ.push_back(want);
	parcelsUsed += 1 + na + nb + nc;
endtask

task automatic randomGroup();
	opcode_t op;
	int cnt [3];
	op = BASE_OPS[int'(randBits(5) % 64'd29)];
	for (int k = 0; k < 3; k++) begin
		if (op == OP_FLT2 || op == OP_FLT3)
			cnt[k] = int'(randBits(1));
		else
			cnt[k] = int'(randBits(2)) % 3;
	end
	buildGroup(op, cnt[0], cnt[1], cnt[2], -1);
endtask

task automatic buildStimulus();
	// Every base class alone, then every integer prefix mix
	for (int i = 0; i < 29; i++)
		buildGroup(BASE_OPS[i], 0, 0, 0, -1);
	for (int m = 0; m < 27; m++)
		buildGroup(OP_ADDI, m % 3, (m / 3) % 3, m / 9, -1);
	for (int c = 0; c < 5; c++) begin
		buildGroup(OP_FLT2, 1, 0, 0, c);
		buildGroup(OP_FLT3, 1, 1, 1, c);
	end
	for (int i = 0; i < 80; i++)
		randomGroup();
	// Trailing parcel that lets the last group leave and stays queued
	sendQ.push_back('0);
endtask

`endif

/* tb/decodeFrontTb.sv */
`default_nettype none

module decodeFrontTb import isaPkg::*, decodePkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int QUEUE_DEPTH = 16;
	localparam int OUT_CREDITS = 4;
	localparam int RUN_LIMIT   = 6000;
	// Downstream returns no credits inside this cycle range
	localparam int STALL_START = 150;
	localparam int STALL_END   = 260;

	logic         clk = 1'b0;
	logic         arstN;
	logic         insValid;
	instruction_t ins;
	groupLen_t    insCredit;
	logic         outValid;
	decodedIns_t  out;
	logic         outCredit;

	instruction_t sendQ [$];
	decodedIns_t  expQ [$];
	int parcelsUsed = 0;
	int bundleErrors = 0;
	int countErrors = 0;
	int otherErrors = 0;
	int upCredits = QUEUE_DEPTH;
	int creditTotal = 0;
	int held = 0;
	int stallSeen = 0;
	int bundles = 0;
	int cycle = 0;

	`include "decodeModel.svh"

	decodeFront #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) i_decodeFront (
		.clk(clk), .arstN(arstN), .insValid(insValid), .ins(ins),
		.insCredit(insCredit), .outValid(outValid), .out(out), .outCredit(outCredit)
	);

	always #4 clk = ~clk;

	// ====================
	// Checks
	// ====================

	task automatic checkBundle(input string name, input decodedIns_t want,
			input decodedIns_t got);
		if (got !== want) begin
			bundleErrors++;
			$display("** Error %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic checkCount(input string name, input int want, input int got);
		if (got != want) begin
			countErrors++;
			$display("** Error %s: expected %0d, actual %0d", name, want, got);
		end
	endtask

	// One clock of traffic, outputs sampled once the edge has settled
	task automatic runCycle();
		logic stall;
		@(posedge clk);
		#1;
		stall = (cycle >= STALL_START) && (cycle < STALL_END);
		creditTotal += int'(insCredit);
		upCredits += int'(insCredit);
		if (upCredits > QUEUE_DEPTH) begin
			otherErrors++;
			$display("Upstream holds %0d credits, more than the queue depth", upCredits);
		end
		if (outValid) begin
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("A bundle arrived with no group outstanding");
			end
			else
				checkBundle($sformatf("bundle %0d", bundles), expQ.pop_front(), out);
			bundles++;
			held++;
			if (stall)
				stallSeen++;
			if (held > OUT_CREDITS) begin
				otherErrors++;
				$display("A bundle arrived while the downstream had no free slot");
			end
		end
		// Upstream sends only while it holds a credit
		insValid = 1'b0;
		ins = '0;
		if (sendQ.size() != 0 && upCredits > 0 && randBits(1) != 64'd0) begin
			insValid = 1'b1;
			ins = sendQ.pop_front();
			upCredits--;
		end
		outCredit = 1'b0;
		if (!stall && held > 0 && randBits(1) != 64'd0) begin
			outCredit = 1'b1;
			held--;
		end
		cycle++;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int guard;
		arstN = 1'b0;
		insValid = 1'b0;
		ins = '0;
		outCredit = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;
		if (outValid !== 1'b0 || insCredit !== '0) begin
			otherErrors++;
			$display("Outputs are not idle after reset");
		end
		buildStimulus();
		guard = 0;
		while ((sendQ.size() != 0 || expQ.size() != 0) && guard < RUN_LIMIT) begin
			runCycle();
			guard++;
		end
		if (guard >= RUN_LIMIT) begin
			otherErrors++;
			$display("Timeout with %0d parcels unsent and %0d bundles missing",
				sendQ.size(), expQ.size());
		end
		else begin
			// Quiet window in which an extra bundle would show up
			repeat (20) runCycle();
			checkCount("insCredit total", parcelsUsed, creditTotal);
			checkCount("upstream credits", QUEUE_DEPTH - 1, upCredits);
			if (stallSeen > OUT_CREDITS) begin
				otherErrors++;
				$display("%0d bundles arrived while credits were withheld", stallSeen);
			end
		end
		$display("Errors: %0d bundle, %0d count, %0d other", bundleErrors, countErrors,
			otherErrors);
		if (bundleErrors + countErrors + otherErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/decodeFront.sv */
`default_nettype none

module decodeFront import isaPkg::*, decodePkg::*; #(
	parameter int QUEUE_DEPTH = 16,
	parameter int OUT_CREDITS = 4
) (
	input  wire               clk,
	input  wire               arstN,
	input  wire               insValid,
	input  wire instruction_t ins,
	output groupLen_t         insCredit,
	output logic              outValid,
	output decodedIns_t       out,
	input  wire               outCredit
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	insWindow_t       window;
	logic [CNT_W-1:0] count;
	logic [63:0]      imma;
	logic [63:0]      immb;
	logic [63:0]      immc;
	prefixCount_t     prefixCount;
	logic             pop;
	groupLen_t        popLen;

	// Parcel queue under upstream credit control
	insQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) uQueue (
		.clk(clk), .arstN(arstN), .insValid(insValid), .ins(ins),
		.pop(pop), .popLen(popLen), .window(window), .count(count),
		.insCredit(insCredit)
	);

	// Immediates of the group at the head of the queue
	decodeImm uImm (
		.window(window), .imma(imma), .immb(immb), .immc(immc),
		.prefixCount(prefixCount)
	);

	decodeStage #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) uStage (
		.clk(clk), .arstN(arstN), .window(window), .count(count),
		.imma(imma), .immb(immb), .immc(immc), .prefixCount(prefixCount),
		.outCredit(outCredit), .pop(pop), .popLen(popLen),
		.outValid(outValid), .out(out)
	);

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`default_nettype none

module decodeStage import isaPkg::*, decodePkg::*; #(
	parameter int QUEUE_DEPTH = 16,
	parameter int OUT_CREDITS = 4,
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1),
	localparam int CRD_W = $clog2(OUT_CREDITS + 1)
) (
	input  wire               clk,
	input  wire               arstN,
	input  wire insWindow_t   window,
	input  wire [CNT_W-1:0]   count,
	input  wire [63:0]        imma,
	input  wire [63:0]        immb,
	input  wire [63:0]        immc,
	input  wire prefixCount_t prefixCount,
	input  wire               outCredit,
	output logic              pop,
	output groupLen_t         popLen,
	output logic              outValid,
	output decodedIns_t       out
);

	logic [CRD_W-1:0] credits;
	logic             groupReady;

	// The parcel after the group must be present so the prefix scan is final
	// A full group of six prefixes has no room for it and goes on its own
	assign groupReady = (count >= CNT_W'(prefixCount) + CNT_W'(2)) ||
		(prefixCount == 3'(MAX_PREFIX) && count >= CNT_W'(WINDOW_LEN));

	// A credit returned in this cycle may be spent at once
	assign pop    = groupReady && (credits != '0 || outCredit);
	assign popLen = groupLen_t'(prefixCount + 3'd1);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			credits <= CRD_W'(OUT_CREDITS);
			outValid <= 1'b0;
		end
		else begin
			credits <= credits + CRD_W'(outCredit) - CRD_W'(pop);
			outValid <= pop;
		end
	end

	// Bundle register loads with the group it pops
	always_ff @(posedge clk) begin
		if (pop) begin
			out.opcode <= window[0].opcode;
			out.ins <= window[0];
			out.imma <= imma;
			out.immb <= immb;
			out.immc <= immc;
			out.prefixCount <= prefixCount;
		end
	end

endmodule

`default_nettype wire

/* hw/insQueue.sv */
`default_nettype none

module insQueue import isaPkg::*, decodePkg::*; #(
	parameter int QUEUE_DEPTH = 16,
	localparam int PTR_W = $clog2(QUEUE_DEPTH),
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1)
) (
	input  wire              clk,
	input  wire              arstN,
	input  wire              insValid,
	input  wire instruction_t ins,
	input  wire              pop,
	input  wire groupLen_t   popLen,
	output insWindow_t       window,
	output logic [CNT_W-1:0] count,
	output groupLen_t        insCredit
);

	instruction_t     mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] popCount;

	// Pointer advance that wraps at any depth, not only powers of two
	function automatic logic [PTR_W-1:0] wrapAdd(input logic [PTR_W-1:0] ptr,
			input logic [2:0] inc);
		logic [PTR_W:0] sum;
		sum = {1'b0, ptr} + (PTR_W + 1)'(inc);
		if (sum >= (PTR_W + 1)'(QUEUE_DEPTH))
			sum = sum - (PTR_W + 1)'(QUEUE_DEPTH);
		return sum[PTR_W-1:0];
	endfunction

	// ====================
	// Head window
	// ====================

	// Slots past the occupancy read as zero so the decoder sees OP_NOP there
	for (genvar i = 0; i < WINDOW_LEN; i++) begin : gWin
		assign window[i] = (CNT_W'(i) < count) ? mem[wrapAdd(rdPtr, 3'(i))] : '0;
	end

	assign popCount = pop ? CNT_W'(popLen) : '0;

	// ====================
	// Storage and pointers
	// ====================

	always_ff @(posedge clk) begin
		if (insValid)
			mem[wrPtr] <= ins;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			insCredit <= '0;
		end
		else begin
			if (insValid)
				wrPtr <= wrapAdd(wrPtr, 3'd1);
			if (pop)
				rdPtr <= wrapAdd(rdPtr, popLen);
			count <= count + CNT_W'(insValid) - popCount;
			// Freed slots go back to the fetch source one cycle after the pop
			insCredit <= pop ? popLen : '0;
		end
	end

endmodule

`default_nettype wire

/* hw/decodeImm.sv */
`default_nettype none

module decodeImm import isaPkg::*, decodePkg::*; (
	input  wire insWindow_t window,
	output logic [63:0]    imma,
	output logic [63:0]    immb,
	output logic [63:0]    immc,
	output prefixCount_t   prefixCount
);

	// Scan order of the prefix kinds, index 0 feeds imma
	localparam opcode_t PFX_OPS [3] = '{OP_PFXA, OP_PFXB, OP_PFXC};

	logic [1:0]  num [3];
	logic [32:0] firstPay [3];
	logic [32:0] secondPay [3];
	logic [63:0] widened [3];
	logic [63:0] imm [3];
	logic [63:0] base;
	logic [15:0] shortImm;
	logic [2:0]  ndx;
	logic        flt;

	// ====================
	// Prefix scan
	// ====================

	always_comb begin
		ndx = 3'd1;
		for (int k = 0; k < 3; k++) begin
			num[k] = 2'd0;
			firstPay[k] = window[ndx].payload;
			secondPay[k] = '0;
			if (window[ndx].opcode == PFX_OPS[k]) begin
				num[k] = 2'd1;
				ndx = ndx + 3'd1;
				secondPay[k] = window[ndx].payload;
				// A repeat of the same kind extends the upper bits
				if (window[ndx].opcode == PFX_OPS[k]) begin
					num[k] = 2'd2;
					ndx = ndx + 3'd1;
				end
			end
		end
		prefixCount = ndx - 3'd1;
	end

	// Float opcodes take the low 32 payload bits as a single-precision constant
	for (genvar k = 0; k < 3; k++) begin : gCvt
		fpCvt32To64 uCvt (
			.src(firstPay[k][31:0]),
			.dst(widened[k])
		);
	end

	// ====================
	// Immediate build
	// ====================

	assign shortImm = window[0][IMM_HI:IMM_LO];
	assign flt = (window[0].opcode == OP_FLT2) || (window[0].opcode == OP_FLT3);

	always_comb begin
		case (window[0].opcode)
			OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_JSR,
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA,
			OP_CACHE, OP_STB, OP_STW, OP_STT, OP_STO:
				base = {{48{shortImm[15]}}, shortImm};
			OP_ANDI:        base = {48'hFFFF_FFFF_FFFF, shortImm};
			OP_ORI, OP_EORI: base = {48'd0, shortImm};
			// Only fourteen bits select a control register
			OP_CSR:         base = {50'd0, shortImm[13:0]};
			// Return displacement stops at 32 bits
			OP_RTD:         base = {32'd0, {16{shortImm[15]}}, shortImm};
			OP_FENCE:       base = {48'd0, window[0][FENCE_HI:FENCE_LO]};
			default:        base = 64'd0;
		endcase
	end

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			// Only the B immediate starts from the base instruction field
			imm[k] = (k == 1) ? base : 64'd0;
			if (num[k] != 2'd0)
				imm[k] = flt ? widened[k] : {{31{firstPay[k][32]}}, firstPay[k]};
			if (num[k] == 2'd2)
				imm[k][63:33] = secondPay[k][30:0];
		end
	end

	assign imma = imm[0];
	assign immb = imm[1];
	assign immc = imm[2];

endmodule

`default_nettype wire

/* hw/fpCvt32To64.sv */
`default_nettype none

module fpCvt32To64 (
	input  wire  [31:0] src,
	output logic [63:0] dst
);

	logic        sign;
	logic [7:0]  exp8;
	logic [22:0] man;
	logic [4:0]  lz;
	logic [22:0] normMan;

	// Position of the first set bit counted from the top of the mantissa
	function automatic logic [4:0] leadZeros(input logic [22:0] m);
		logic [4:0] n;
		logic found;
		n = 5'd0;
		found = 1'b0;
		for (int i = 22; i >= 0; i--) begin
			if (!found && m[i]) begin
				n = 5'(22 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	assign sign = src[31];
	assign exp8 = src[30:23];
	assign man  = src[22:0];

	// Shifting one past the leading one leaves the hidden bit implied
	assign lz      = leadZeros(man);
	assign normMan = man << (lz + 5'd1);

	always_comb begin
		if (exp8 == 8'd0) begin
			if (man == 23'd0)
				dst = {sign, 63'd0};
			else
				// Denormal value is man * 2^-149 so the biased exponent is 896 - lz
				dst = {sign, 11'd896 - 11'(lz), normMan, 29'd0};
		end
		else if (exp8 == 8'hFF)
			// Infinity has a zero mantissa and NaN keeps its payload at the top
			dst = {sign, 11'h7FF, man, 29'd0};
		else
			// Re-bias from 127 to 1023
			dst = {sign, 11'(exp8) + 11'd896, man, 29'd0};
	end

endmodule

`default_nettype wire

/* hw/decodePkg.sv */
`default_nettype none

package decodePkg;
	import isaPkg::*;

	// Parcels visible to the decoder at once
	localparam int WINDOW_LEN = 7;
	// Two prefixes of each of the three kinds
	localparam int MAX_PREFIX = 6;

	// Entry 0 holds the oldest parcel, the base instruction of the group
	typedef instruction_t [WINDOW_LEN-1:0] insWindow_t;

	// Number of parcels removed from the queue together, base plus prefixes
	typedef logic [2:0] groupLen_t;
	typedef logic [2:0] prefixCount_t;

	// Bundle handed to the downstream stage
	typedef struct packed {
		opcode_t      opcode;
		instruction_t ins;
		logic [63:0]  imma;
		logic [63:0]  immb;
		logic [63:0]  immc;
		prefixCount_t prefixCount;
	} decodedIns_t;

endpackage

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

	// ====================
	// Opcodes
	// ====================

	// Seven bit major opcode in the low bits of every parcel
	// Zero is the no-operation and is also what an empty window slot reads as
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADDI  = 7'd4,
		OP_CMPI  = 7'd5,
		OP_MULI  = 7'd6,
		OP_DIVI  = 7'd7,
		OP_SUBFI = 7'd8,
		OP_SLTI  = 7'd9,
		OP_ANDI  = 7'd10,
		OP_ORI   = 7'd11,
		OP_EORI  = 7'd12,
		OP_CSR   = 7'd15,
		OP_RTD   = 7'd16,
		OP_JSR   = 7'd17,
		OP_LDB   = 7'd32,
		OP_LDBU  = 7'd33,
		OP_LDW   = 7'd34,
		OP_LDWU  = 7'd35,
		OP_LDT   = 7'd36,
		OP_LDTU  = 7'd37,
		OP_LDO   = 7'd38,
		OP_LDA   = 7'd39,
		OP_CACHE = 7'd40,
		OP_STB   = 7'd48,
		OP_STW   = 7'd49,
		OP_STT   = 7'd50,
		OP_STO   = 7'd51,
		OP_FENCE = 7'd60,
		OP_FLT2  = 7'd66,
		OP_FLT3  = 7'd67,
		// Immediate extension parcels follow the base instruction in A, B, C order
		OP_PFXA  = 7'd120,
		OP_PFXB  = 7'd121,
		OP_PFXC  = 7'd122
	} opcode_t;

	// ====================
	// Parcel layout
	// ====================

	// A 40-bit parcel is the opcode plus a 33-bit payload used whole by the prefixes
	typedef struct packed {
		logic [32:0] payload;
		opcode_t     opcode;
	} instruction_t;

	// Bit positions of the fields carried inside the payload of a base instruction
	localparam int IMM_HI   = 34;
	localparam int IMM_LO   = 19;
	localparam int FENCE_HI = 23;
	localparam int FENCE_LO = 8;

endpackage

`default_nettype wire
